// ==== hw/rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

////////////////////
// table sizes
////////////////////

`define ARF_SIZE	32	// architectural registers
`define PRF_SIZE	64	// physical registers

// slots renamed per group
`define GROUP_WIDTH	2

`endif

// ==== hw/rename_pkg.sv ====
`include "rename_consts.svh"

package rename_pkg;

	////////////////////
	// index types
	////////////////////

	typedef logic [$clog2(`ARF_SIZE)-1:0] arch_idx_t;	// arch reg number
	typedef logic [$clog2(`PRF_SIZE)-1:0] phys_idx_t;	// physical tag

	////////////////////
	// rename side
	////////////////////

	typedef struct packed {
		logic		valid;		// slot holds an instruction
		logic		dest_en;	// dest needs a new tag
		arch_idx_t	dest_arch;
		logic		src_a_en;	// low means immediate
		arch_idx_t	src_a_arch;
		logic		src_b_en;	// low means immediate
		arch_idx_t	src_b_arch;
	} rename_slot_t;

	typedef rename_slot_t [`GROUP_WIDTH-1:0] rename_group_t;	// slot 0 is oldest

	typedef struct packed {
		logic		valid;
		phys_idx_t	src_a_phys;	// 0 for immediates
		phys_idx_t	src_b_phys;
		phys_idx_t	dest_phys;	// newly allocated tag
		phys_idx_t	prev_phys;	// tag freed when this one commits
	} renamed_slot_t;

	typedef renamed_slot_t [`GROUP_WIDTH-1:0] renamed_group_t;

	////////////////////
	// retire side
	////////////////////

	typedef struct packed {
		logic		valid;		// one-cycle strobe
		arch_idx_t	dest_arch;
		phys_idx_t	dest_phys;
	} commit_t;

	typedef enum logic [2:0] {
		ctrl_idle,
		ctrl_lookup,		// table read and alloc this cycle
		ctrl_hold,		// rename ack up, wait for req low
		ctrl_recover,		// walker running
		ctrl_recover_hold	// recover ack up, wait for req low
	} ctrl_state_t;

endpackage

// ==== hw/rename_ctrl.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_ctrl import rename_pkg::*; (
	input	logic				clock,
	input	logic				reset,
	input	logic				rename_req,
	output	logic				rename_ack,
	input	logic				recover_req,
	output	logic				recover_ack,
	input	logic [`GROUP_WIDTH-1:0]	group_needs,	// slots that need a dest tag
	input	logic				tags_ok,	// enough free tags for this group
	input	logic				walk_last,	// walker on its final entry
	output	logic				alloc_en,
	output	logic				walk_start
);

	ctrl_state_t	state;
	ctrl_state_t	state_next;
	logic		rename_go;

	// a group without dests never waits on the free list
	assign rename_go = rename_req & (tags_ok | ~|group_needs);

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			ctrl_idle: begin
				if (recover_req)	// recovery beats a waiting rename
					state_next = ctrl_recover;
				else if (rename_go)
					state_next = ctrl_lookup;
			end
			ctrl_lookup: begin
				state_next = ctrl_hold;	// table written on this edge
			end
			ctrl_hold: begin
				if (!rename_req)
					state_next = ctrl_idle;
			end
			ctrl_recover: begin
				if (walk_last)
					state_next = ctrl_recover_hold;
			end
			ctrl_recover_hold: begin
				if (!recover_req)
					state_next = ctrl_idle;
			end
			default: begin
				state_next = ctrl_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= ctrl_idle;
		else
			state <= state_next;
	end

	////////////////////
	// outputs
	////////////////////

	assign alloc_en    = (state == ctrl_lookup);		// one cycle per group
	assign rename_ack  = (state == ctrl_hold);
	assign recover_ack = (state == ctrl_recover_hold);
	assign walk_start  = (state == ctrl_idle) & recover_req;	// only cycle before recover

endmodule

// ==== hw/recover_walker.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module recover_walker import rename_pkg::*; (
	input	logic		clock,
	input	logic		reset,
	input	logic		walk_start,
	output	arch_idx_t	walk_idx,	// arch entry restored this cycle
	output	logic		walk_active,
	output	logic		walk_last
);

	localparam arch_idx_t last_idx = arch_idx_t'(`ARF_SIZE - 1);

	////////////////////
	// step counter
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			walk_active <= 1'b0;
			walk_idx    <= '0;
		end else if (walk_start) begin
			walk_active <= 1'b1;	// entry 0 on the next cycle
			walk_idx    <= '0;
		end else if (walk_active) begin
			if (walk_idx == last_idx)
				walk_active <= 1'b0;	// ARF_SIZE cycles in all
			else
				walk_idx <= walk_idx + 1'b1;
		end
	end

	// high during the final step only
	assign walk_last = walk_active & (walk_idx == last_idx);

endmodule

// ==== hw/map_table.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module map_table import rename_pkg::*; (
	input	logic			clock,
	input	logic			reset,
	input	rename_group_t		rename_group,
	input	logic			alloc_en,
	input	phys_idx_t [1:0]	free_tags,	// two lowest free, [0] lower
	input	logic			walk_active,
	input	arch_idx_t		walk_idx,
	input	phys_idx_t		arch_phys,	// retirement entry at walk_idx
	output	renamed_group_t		renamed_group
);

	phys_idx_t [`ARF_SIZE-1:0]	map_q;		// speculative arch to phys
	renamed_group_t			lookup;
	phys_idx_t [1:0]		new_tag;
	logic [`GROUP_WIDTH-1:0]	writes;		// slot renames its dest
	logic				hit_a;
	logic				hit_b;
	logic				hit_d;

	////////////////////
	// tag assignment
	////////////////////

	always_comb begin
		writes[0] = rename_group[0].valid & rename_group[0].dest_en;
		writes[1] = rename_group[1].valid & rename_group[1].dest_en;
		new_tag[0] = free_tags[0];
		new_tag[1] = writes[0] ? free_tags[1] : free_tags[0];	// packed toward lowest
	end

	////////////////////
	// lookup and bypass
	////////////////////

	always_comb begin
		// slot 1 names slot 0's dest
		hit_a = writes[0] & (rename_group[0].dest_arch == rename_group[1].src_a_arch);
		hit_b = writes[0] & (rename_group[0].dest_arch == rename_group[1].src_b_arch);
		hit_d = writes[0] & (rename_group[0].dest_arch == rename_group[1].dest_arch);

		// slot 0 reads the table only
		lookup[0].valid      = rename_group[0].valid;
		lookup[0].src_a_phys = rename_group[0].src_a_en ?
			map_q[rename_group[0].src_a_arch] : '0;	// immediate reads 0
		lookup[0].src_b_phys = rename_group[0].src_b_en ?
			map_q[rename_group[0].src_b_arch] : '0;
		lookup[0].dest_phys  = writes[0] ? new_tag[0] : '0;
		lookup[0].prev_phys  = writes[0] ? map_q[rename_group[0].dest_arch] : '0;

		// slot 1 sees slot 0's new tag
		lookup[1].valid      = rename_group[1].valid;
		lookup[1].src_a_phys = !rename_group[1].src_a_en ? '0 :
			hit_a ? new_tag[0] : map_q[rename_group[1].src_a_arch];
		lookup[1].src_b_phys = !rename_group[1].src_b_en ? '0 :
			hit_b ? new_tag[0] : map_q[rename_group[1].src_b_arch];
		lookup[1].dest_phys  = writes[1] ? new_tag[1] : '0;
		lookup[1].prev_phys  = !writes[1] ? '0 :
			hit_d ? new_tag[0] : map_q[rename_group[1].dest_arch];

		if (!rename_group[0].valid)
			lookup[0] = '0;	// empty slot reports nothing
		if (!rename_group[1].valid)
			lookup[1] = '0;
	end

	////////////////////
	// table update
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++)
				map_q[i] <= phys_idx_t'(i);	// identity map
		end else if (walk_active) begin
			map_q[walk_idx] <= arch_phys;	// copy back from retirement map
		end else if (alloc_en) begin
			if (writes[0])
				map_q[rename_group[0].dest_arch] <= new_tag[0];
			if (writes[1])
				map_q[rename_group[1].dest_arch] <= new_tag[1];	// younger wins
		end
	end

	// result register, held until the next group
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `GROUP_WIDTH; i++)
				renamed_group[i].valid <= 1'b0;
		end else if (alloc_en) begin
			renamed_group <= lookup;
		end
	end

endmodule

// ==== hw/retire_map.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module retire_map import rename_pkg::*; (
	input	logic		clock,
	input	logic		reset,
	input	commit_t	commit,
	input	arch_idx_t	walk_idx,
	output	phys_idx_t	arch_phys,	// committed tag at walk_idx
	output	logic		freed_valid,
	output	phys_idx_t	freed_tag
);

	phys_idx_t [`ARF_SIZE-1:0]	rmap_q;	// committed arch to phys

	////////////////////
	// commit write
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++)
				rmap_q[i] <= phys_idx_t'(i);	// identity map
		end else if (commit.valid) begin
			rmap_q[commit.dest_arch] <= commit.dest_phys;
		end
	end

	////////////////////
	// read ports
	////////////////////

	// overwritten tag goes back to the free list on the commit edge
	assign freed_valid = commit.valid;
	assign freed_tag   = rmap_q[commit.dest_arch];

	assign arch_phys = rmap_q[walk_idx];	// recovery source

endmodule

// ==== hw/free_list.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module free_list import rename_pkg::*; (
	input	logic				clock,
	input	logic				reset,
	input	logic				alloc_en,
	input	logic [`GROUP_WIDTH-1:0]	group_needs,	// slots taking a tag
	input	logic				freed_valid,
	input	phys_idx_t			freed_tag,
	input	logic				walk_start,
	input	logic				walk_active,
	input	phys_idx_t			arch_phys,	// tag still committed
	output	phys_idx_t [1:0]		free_tags,	// [0] is the lowest
	output	logic				tags_ok
);

	logic [`PRF_SIZE-1:0]	free_q;		// one bit per tag, high is free
	logic [`PRF_SIZE-1:0]	free_next;
	logic [1:0]		need_cnt;
	logic			found0;
	logic			found1;

	assign need_cnt = {1'b0, group_needs[0]} + {1'b0, group_needs[1]};

	////////////////////
	// two lowest free
	////////////////////

	always_comb begin
		found0       = 1'b0;
		found1       = 1'b0;
		free_tags[0] = '0;
		free_tags[1] = '0;
		for (int i = 0; i < `PRF_SIZE; i++) begin
			if (free_q[i] && !found0) begin
				free_tags[0] = phys_idx_t'(i);
				found0       = 1'b1;
			end else if (free_q[i] && !found1) begin
				free_tags[1] = phys_idx_t'(i);	// second lowest
				found1       = 1'b1;
			end
		end
	end

	// enough tags for every dest in the group
	assign tags_ok = (need_cnt == 2'd0) | (found0 & (need_cnt == 2'd1)) | found1;

	////////////////////
	// bit updates
	////////////////////

	always_comb begin
		free_next = free_q;
		if (alloc_en && need_cnt != 2'd0)
			free_next[free_tags[0]] = 1'b0;
		if (alloc_en && need_cnt == 2'd2)
			free_next[free_tags[1]] = 1'b0;
		if (freed_valid)
			free_next[freed_tag] = 1'b1;	// commit return
		if (walk_active)
			free_next[arch_phys] = 1'b0;	// held by the retirement map
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PRF_SIZE; i++)
				free_q[i] <= (i >= `ARF_SIZE);	// low tags start mapped
		end else if (walk_start) begin
			free_q <= '1;	// rebuilt by the walk
		end else begin
			free_q <= free_next;
		end
	end

endmodule

// ==== hw/rename_unit.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_unit import rename_pkg::*; (
	input	logic			clock,
	input	logic			reset,
	input	logic			rename_req,
	input	rename_group_t		rename_group,
	output	logic			rename_ack,
	output	renamed_group_t		renamed_group,
	input	logic			recover_req,
	output	logic			recover_ack,
	input	commit_t		commit
);

	logic [`GROUP_WIDTH-1:0]	group_needs;
	logic				tags_ok;
	logic				alloc_en;
	logic				walk_start;
	logic				walk_active;
	logic				walk_last;
	arch_idx_t			walk_idx;
	phys_idx_t			arch_phys;
	phys_idx_t [1:0]		free_tags;
	logic				freed_valid;
	phys_idx_t			freed_tag;

	// one bit per slot that will take a tag
	always_comb begin
		for (int i = 0; i < `GROUP_WIDTH; i++)
			group_needs[i] = rename_group[i].valid & rename_group[i].dest_en;
	end

	////////////////////
	// control
	////////////////////

	rename_ctrl ctrl_i (
		.clock		(clock),
		.reset		(reset),
		.rename_req	(rename_req),
		.rename_ack	(rename_ack),
		.recover_req	(recover_req),
		.recover_ack	(recover_ack),
		.group_needs	(group_needs),
		.tags_ok	(tags_ok),
		.walk_last	(walk_last),
		.alloc_en	(alloc_en),
		.walk_start	(walk_start)
	);

	recover_walker walker_i (
		.clock		(clock),
		.reset		(reset),
		.walk_start	(walk_start),
		.walk_idx	(walk_idx),
		.walk_active	(walk_active),
		.walk_last	(walk_last)
	);

	////////////////////
	// tables
	////////////////////

	map_table map_i (
		.clock		(clock),
		.reset		(reset),
		.rename_group	(rename_group),
		.alloc_en	(alloc_en),
		.free_tags	(free_tags),
		.walk_active	(walk_active),
		.walk_idx	(walk_idx),
		.arch_phys	(arch_phys),
		.renamed_group	(renamed_group)
	);

	retire_map rmap_i (
		.clock		(clock),
		.reset		(reset),
		.commit		(commit),
		.walk_idx	(walk_idx),
		.arch_phys	(arch_phys),
		.freed_valid	(freed_valid),
		.freed_tag	(freed_tag)
	);

	free_list flist_i (
		.clock		(clock),
		.reset		(reset),
		.alloc_en	(alloc_en),
		.group_needs	(group_needs),
		.freed_valid	(freed_valid),
		.freed_tag	(freed_tag),
		.walk_start	(walk_start),
		.walk_active	(walk_active),
		.arch_phys	(arch_phys),
		.free_tags	(free_tags),
		.tags_ok	(tags_ok)
	);

endmodule

// ==== verification/rename_unit_tb.sv ====
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_unit_tb import rename_pkg::*; ();

	localparam int max_wait = 3 * `ARF_SIZE;	// longest wait is the walk

	logic			clock;
	logic			reset;
	logic			rename_req;
	rename_group_t		rename_group;
	logic			rename_ack;
	renamed_group_t		renamed_group;
	logic			recover_req;
	logic			recover_ack;
	commit_t		commit;

	phys_idx_t		spec_map [`ARF_SIZE];	// model speculative map
	phys_idx_t		ret_map [`ARF_SIZE];	// model retirement map
	logic [`PRF_SIZE-1:0]	free_bits;		// high is free
	arch_idx_t		seq_arch [$];		// one entry per dest slot in rename order
	phys_idx_t		seq_phys [$];
	phys_idx_t		seq_prev [$];
	logic			seq_live [$];		// renamed but not yet committed or squashed
	logic			pending;		// group held back by the free list

	rename_unit dut_i (
		.clock		(clock),
		.reset		(reset),
		.rename_req	(rename_req),
		.rename_group	(rename_group),
		.rename_ack	(rename_ack),
		.renamed_group	(renamed_group),
		.recover_req	(recover_req),
		.recover_ack	(recover_ack),
		.commit		(commit)
	);

	always #20 clock = ~clock;	// 40 ns period

	////////////////////
	// checks
	////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_renamed(input string name, input renamed_slot_t got,
		input renamed_slot_t want);
		if (got !== want)
			fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, want));
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
			fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, want));
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;	// clear of the edge
	endtask

	task automatic wait_rename_ack(input logic level);
		int n;
		n = 0;
		while (rename_ack !== level) begin
			if (n == max_wait) begin
				if (level)
					fail_run("timeout, rename_ack never rose");
				else
					fail_run("timeout, rename_ack never fell");
			end
			next_cycle();
			n++;
		end
	endtask

	task automatic wait_recover_ack(input logic level);
		int n;
		n = 0;
		while (recover_ack !== level) begin
			if (n == max_wait) begin
				if (level)
					fail_run("timeout, recover_ack never rose");
				else
					fail_run("timeout, recover_ack never fell");
			end
			next_cycle();
			n++;
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	function automatic int free_count();
		int n;
		n = 0;
		for (int i = 0; i < `PRF_SIZE; i++)
			if (free_bits[i])
				n++;
		return n;
	endfunction

	function automatic int tags_needed(input rename_group_t g);
		int n;
		n = 0;
		for (int s = 0; s < `GROUP_WIDTH; s++)
			if (g[s].valid && g[s].dest_en)
				n++;
		return n;
	endfunction

	function automatic phys_idx_t lowest_free();
		for (int i = 0; i < `PRF_SIZE; i++)
			if (free_bits[i])
				return phys_idx_t'(i);
		return '0;
	endfunction

	function automatic rename_slot_t make_slot(input int v, d, dst, ae, a, be, b);
		rename_slot_t s;
		s.valid      = v[0];
		s.dest_en    = d[0];
		s.dest_arch  = arch_idx_t'(dst);
		s.src_a_en   = ae[0];
		s.src_a_arch = arch_idx_t'(a);
		s.src_b_en   = be[0];
		s.src_b_arch = arch_idx_t'(b);
		return s;
	endfunction

	// slot 1 reads what slot 0 wrote
	task automatic predict_rename(input rename_group_t g, output renamed_group_t want);
		phys_idx_t tag;
		want = '0;
		for (int s = 0; s < `GROUP_WIDTH; s++) begin
			if (g[s].valid) begin
				want[s].valid = 1'b1;
				if (g[s].src_a_en)
					want[s].src_a_phys = spec_map[g[s].src_a_arch];	// immediates keep 0
				if (g[s].src_b_en)
					want[s].src_b_phys = spec_map[g[s].src_b_arch];
				if (g[s].dest_en) begin
					tag = lowest_free();
					free_bits[tag] = 1'b0;
					want[s].dest_phys = tag;
					want[s].prev_phys = spec_map[g[s].dest_arch];
					spec_map[g[s].dest_arch] = tag;
					seq_arch.push_back(g[s].dest_arch);
					seq_phys.push_back(tag);
					seq_prev.push_back(want[s].prev_phys);
					seq_live.push_back(1'b1);
				end
			end
		end
	endtask

	task automatic model_recover();
		free_bits = '1;
		for (int i = 0; i < `ARF_SIZE; i++) begin
			spec_map[i] = ret_map[i];
			free_bits[ret_map[i]] = 1'b0;	// still committed
		end
		for (int i = 0; i < seq_live.size(); i++)
			seq_live[i] = 1'b0;	// squashed
	endtask

	////////////////////
	// bus drivers
	////////////////////

	task automatic start_rename(input rename_group_t g);
		next_cycle();	// one cycle with req low first
		check_flag("rename_ack", rename_ack, 1'b0);	// no ack ahead of req
		rename_group = g;
		rename_req   = 1'b1;
	endtask

	task automatic hold_stalled();
		repeat (3) begin
			next_cycle();
			check_flag("rename_ack", rename_ack, 1'b0);	// free list back-pressure
		end
	endtask

	task automatic finish_rename();
		renamed_group_t want;
		predict_rename(rename_group, want);
		wait_rename_ack(1'b1);
		check_renamed("renamed_group[0]", renamed_group[0], want[0]);
		check_renamed("renamed_group[1]", renamed_group[1], want[1]);
		next_cycle();
		check_flag("rename_ack", rename_ack, 1'b1);	// held while req high
		rename_req = 1'b0;
		wait_rename_ack(1'b0);
	endtask

	task automatic run_commit(input int seq);
		phys_idx_t old;
		if (seq < 0 || seq >= seq_arch.size() || !seq_live[seq])
			fail_run($sformatf("commit of sequence %0d, which is not in flight", seq));
		old = ret_map[seq_arch[seq]];
		if (old !== seq_prev[seq])
			fail_run($sformatf("commit of sequence %0d is out of program order", seq));
		commit.valid     = 1'b1;
		commit.dest_arch = seq_arch[seq];
		commit.dest_phys = seq_phys[seq];
		next_cycle();
		commit = '0;	// one-cycle strobe
		ret_map[seq_arch[seq]] = seq_phys[seq];
		free_bits[old] = 1'b1;	// overwritten tag returns
		seq_live[seq] = 1'b0;
	endtask

	task automatic run_recovery();
		check_flag("recover_ack", recover_ack, 1'b0);
		recover_req = 1'b1;
		model_recover();
		wait_recover_ack(1'b1);
		next_cycle();
		check_flag("recover_ack", recover_ack, 1'b1);	// held while req high
		recover_req = 1'b0;
		wait_recover_ack(1'b0);
	endtask

	////////////////////
	// case file
	////////////////////

	initial begin
		int		fd;
		int		code;
		int		count;
		int		seq;
		int		f [14];
		string		line;
		rename_group_t	g;

		clock        = 1'b0;
		reset        = 1'b1;
		rename_req   = 1'b0;
		rename_group = '0;
		recover_req  = 1'b0;
		commit       = '0;
		pending      = 1'b0;
		for (int i = 0; i < `ARF_SIZE; i++) begin
			spec_map[i] = phys_idx_t'(i);	// identity at reset
			ret_map[i]  = phys_idx_t'(i);
		end
		free_bits = {{(`PRF_SIZE - `ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};	// upper tags free
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		check_flag("rename_ack", rename_ack, 1'b0);
		check_flag("recover_ack", recover_ack, 1'b0);
		check_flag("renamed_group[0].valid", renamed_group[0].valid, 1'b0);
		check_flag("renamed_group[1].valid", renamed_group[1].valid, 1'b0);

		fd = $fopen("verification/rename_cases.txt", "r");
		if (fd == 0)
			fail_run("cannot open verification/rename_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;	// blank or comment
			case (line.getc(0))
				"R": begin
					code = $sscanf(line, "R %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
						count, f[0], f[1], f[2], f[3], f[4], f[5], f[6],
						f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
					if (code != 15 || pending)
						fail_run($sformatf("bad or misplaced rename line: %s", line));
					g[0] = make_slot(f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
					g[1] = make_slot(f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
					for (int r = 0; r < count; r++) begin
						start_rename(g);
						if (free_count() >= tags_needed(g)) begin
							finish_rename();
						end else begin
							if (r != count - 1)
								fail_run("a repeated rename line stalls before its last group");
							pending = 1'b1;	// req stays up
							hold_stalled();
						end
					end
				end
				"C": begin
					code = $sscanf(line, "C %d", seq);
					if (code != 1)
						fail_run($sformatf("bad commit line: %s", line));
					run_commit(seq);
					if (pending && free_count() >= tags_needed(rename_group)) begin
						finish_rename();	// enough tags came back
						pending = 1'b0;
					end else if (pending) begin
						hold_stalled();
					end
				end
				"V": begin
					if (pending)
						fail_run("recovery line while a rename is stalled");
					run_recovery();
				end
				default: begin
					fail_run($sformatf("unknown line in case file: %s", line));
				end
			endcase
		end
		$fclose(fd);
		if (pending) begin
			fail_run("case file ends while a rename is stalled");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// ==== rename_unit.f ====
+incdir+hw
hw/rename_pkg.sv
hw/rename_ctrl.sv
hw/recover_walker.sv
hw/map_table.sv
hw/retire_map.sv
hw/free_list.sv
hw/rename_unit.sv
verification/rename_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the rename unit

SRCS := $(filter-out +%,$(shell cat rename_unit.f)) hw/rename_consts.svh

obj_dir/Vrename_unit_tb: rename_unit.f $(SRCS)
	verilator --binary --timing -f rename_unit.f --top-module rename_unit_tb

# the pipe status is the status of grep, so a missing pass line fails the target
run: obj_dir/Vrename_unit_tb
	./obj_dir/Vrename_unit_tb | tee /dev/stderr | grep -q '^NO ERRORS$$'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== verification/rename_cases.txt ====
# R count, slot 0: valid dest_en dest src_a_en src_a src_b_en src_b, slot 1: same seven fields
# C seq commits the dest slot with that number (dest slots count from 0), V runs a recovery
# first group after reset, slot 1 reads slot 0's dest
R 1  1 1 3 1 1 1 2  1 1 4 1 3 0 0
# repeated dest and immediates
R 1  1 1 5 0 0 1 6  1 1 5 1 5 1 5
# no dest in slot 0, slot 1 empty
R 1  1 0 0 1 3 1 4  0 0 0 0 0 0 0
# slot 0 empty
R 1  0 0 0 0 0 0 0  1 1 7 1 7 0 0
# commits return 3 and 4 for the next group
C 0
C 1
R 1  1 1 8 1 3 1 4  1 1 9 1 8 1 5
# drain the free list down to nothing
R 13 1 1 10 1 1 1 2  1 1 11 1 10 0 0
R 1  1 1 14 1 0 0 0  0 0 0 0 0 0 0
# stalls until two commits have returned tags
R 1  1 1 12 1 14 1 10  1 1 13 1 12 1 11
C 2
C 3
C 4
C 5
# recovery with seq 6 to 35 still in flight
V
R 1  1 1 3 1 3 1 8  1 1 20 1 5 1 7
C 36
R 1  1 1 22 0 0 0 0  0 0 0 0 0 0 0
# second recovery squashes seq 37 and 38
V
R 1  1 1 20 1 20 1 3  1 1 21 1 4 1 8
C 39
R 1  1 1 23 1 21 1 20  1 0 0 1 22 1 23
